// ==== all.f ====
verilog/soc_cfg_pkg.sv
verilog/soc_cmd_pkg.sv
verilog/domain_seq.sv
verilog/bank_ram.sv
verilog/domain_ctrl.sv
verilog/soc_board_top.sv
bench/tb_soc_board_top.sv

// ==== Makefile ====
TOP := tb_soc_board_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --top-module soc_board_top \
		verilog/soc_cfg_pkg.sv verilog/soc_cmd_pkg.sv verilog/domain_seq.sv \
		verilog/bank_ram.sv verilog/domain_ctrl.sv verilog/soc_board_top.sv
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== bench/tb_soc_board_top.sv ====
`timescale 1ns/10ps

module tb_soc_board_top;

    localparam int MAX_ENTRIES = 72;
    localparam int RSP_TIMEOUT = 100;
    localparam int NB          = soc_cfg_pkg::NO_BANKS;

    logic          clk;
    logic          cpu_resetn;
    logic          cmd_valid;
    logic [31:0]   cmd_word;
    logic          rsp_valid;
    logic [15:0]   rsp_data;
    logic          rsp_err;
    logic          busy;
    logic [NB-1:0] bank_paused;

    // one row per command, expected err, data and bank_paused after it
    logic [31:0]   cmd_tab    [MAX_ENTRIES];
    logic          err_tab    [MAX_ENTRIES];
    logic [15:0]   data_tab   [MAX_ENTRIES];
    logic [NB-1:0] paused_tab [MAX_ENTRIES];
    logic          drop_tab   [MAX_ENTRIES];
    int            test_tab   [MAX_ENTRIES];
    int            n_entries;

    // shadow of bank contents and pause state
    logic [15:0]   shadow  [NB][soc_cfg_pkg::BANK_DEPTH];
    bit            written [NB][soc_cfg_pkg::BANK_DEPTH];
    logic [NB-1:0] sh_paused;

    string  test_name [6];
    integer seed;
    int     errors;
    int     checks;
    int     failed_tests;

    soc_board_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog sized from the table length
    initial begin
        repeat (MAX_ENTRIES * 200 + 100) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    // memory view, op bank addr data from the top
    function automatic logic [31:0] mem_cmd(input logic [3:0] op, input logic [1:0] bank,
                                            input logic [9:0] addr, input logic [15:0] data);
        return {op, bank, addr, data};
    endfunction

    function automatic logic [31:0] ctrl_cmd(input logic [3:0] op, input logic [2:0] mask);
        return {op, mask, 25'd0};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // append a row, then move the shadow past that command
    task automatic add_entry(input int test, input logic [31:0] cmd, input logic err,
                             input logic drop);
        logic [3:0] op;
        int         bank;
        logic [9:0] addr;
        op   = cmd[31:28];
        bank = int'(cmd[27:26]);
        addr = cmd[25:16];
        data_tab[n_entries] = '0;
        if (op == soc_cmd_pkg::OP_READ && !err) begin
            data_tab[n_entries] = shadow[bank][addr];
        end else if (op == soc_cmd_pkg::OP_WRITE && !err) begin
            shadow[bank][addr]  = cmd[15:0];
            written[bank][addr] = 1'b1;
        end else if (op == soc_cmd_pkg::OP_PAUSE) begin
            sh_paused = sh_paused | cmd[27:25];
        end else if (op == soc_cmd_pkg::OP_RESUME || op == soc_cmd_pkg::OP_RESET) begin
            sh_paused = sh_paused & ~cmd[27:25];
        end
        cmd_tab[n_entries]    = cmd;
        err_tab[n_entries]    = err;
        paused_tab[n_entries] = sh_paused;
        drop_tab[n_entries]   = drop;
        test_tab[n_entries]   = test;
        n_entries++;
    endtask

    task automatic build_table();
        logic [9:0]  addrs [8];
        logic [31:0] r;
        int          bank;
        logic [9:0]  addr;
        logic        wr;
        logic        err;
        addrs = '{10'h000, 10'h155, 10'h3ff, 10'h001, 10'h2aa, 10'h100, 10'h0f0, 10'h37c};
        n_entries = 0;
        sh_paused = '0;
        // three addresses per bank, written first and read back after
        for (int b = 0; b < NB; b++) begin
            for (int a = 0; a < 3; a++) begin
                r = $random(seed);
                add_entry(1, mem_cmd(soc_cmd_pkg::OP_WRITE, 2'(b), addrs[a], r[15:0]), 0, 0);
            end
        end
        for (int b = 0; b < NB; b++) begin
            for (int a = 0; a < 3; a++) begin
                add_entry(1, mem_cmd(soc_cmd_pkg::OP_READ, 2'(b), addrs[a], 16'h0), 0, 0);
            end
        end
        r = $random(seed);
        add_entry(1, mem_cmd(soc_cmd_pkg::OP_WRITE, 2'd1, addrs[1], r[15:0]), 0, 0);
        add_entry(1, mem_cmd(soc_cmd_pkg::OP_READ, 2'd1, addrs[1], 16'h0), 0, 0);
        // banks 0 and 2 paused, bank 1 still served
        add_entry(2, ctrl_cmd(soc_cmd_pkg::OP_PAUSE, 3'b101), 0, 0);
        add_entry(2, mem_cmd(soc_cmd_pkg::OP_READ, 2'd0, addrs[0], 16'h0), 1, 0);
        add_entry(2, mem_cmd(soc_cmd_pkg::OP_WRITE, 2'd2, addrs[2], 16'hdead), 1, 0);
        add_entry(2, mem_cmd(soc_cmd_pkg::OP_READ, 2'd1, addrs[1], 16'h0), 0, 0);
        add_entry(3, ctrl_cmd(soc_cmd_pkg::OP_RESUME, 3'b001), 0, 0);
        add_entry(3, mem_cmd(soc_cmd_pkg::OP_READ, 2'd0, addrs[0], 16'h0), 0, 0);
        add_entry(3, ctrl_cmd(soc_cmd_pkg::OP_RESET, 3'b100), 0, 0);
        add_entry(3, mem_cmd(soc_cmd_pkg::OP_READ, 2'd2, addrs[2], 16'h0), 0, 0);
        add_entry(3, ctrl_cmd(soc_cmd_pkg::OP_RESET, 3'b010), 0, 0);
        add_entry(3, mem_cmd(soc_cmd_pkg::OP_READ, 2'd1, addrs[1], 16'h0), 0, 0);
        // unused opcodes and bank number 3
        add_entry(4, mem_cmd(4'h0, 2'd0, addrs[0], 16'h1234), 1, 0);
        add_entry(4, mem_cmd(4'h6, 2'd0, addrs[0], 16'h1234), 1, 0);
        add_entry(4, mem_cmd(4'hf, 2'd0, addrs[0], 16'h1234), 1, 0);
        add_entry(4, mem_cmd(soc_cmd_pkg::OP_READ, 2'd3, addrs[0], 16'h0), 1, 0);
        add_entry(4, mem_cmd(soc_cmd_pkg::OP_WRITE, 2'd3, addrs[0], 16'h5678), 1, 0);
        r = $random(seed);
        add_entry(4, mem_cmd(soc_cmd_pkg::OP_WRITE, 2'd0, addrs[0], r[15:0]), 0, 1);
        add_entry(4, mem_cmd(soc_cmd_pkg::OP_READ, 2'd0, addrs[0], 16'h0), 0, 0);
        // random fill, a read of an unwritten word becomes a write
        while (n_entries < MAX_ENTRIES) begin
            r    = $random(seed);
            bank = int'(r[1:0]);
            addr = addrs[r[4:2]];
            wr   = r[5] || (bank < NB && !written[bank][addr]);
            err  = (bank >= NB) || sh_paused[bank];
            if (wr) begin
                add_entry(5, mem_cmd(soc_cmd_pkg::OP_WRITE, r[1:0], addr, r[31:16]), err, 0);
            end else begin
                add_entry(5, mem_cmd(soc_cmd_pkg::OP_READ, r[1:0], addr, 16'h0), err, 0);
            end
        end
    endtask

    task automatic apply_entry(input int i);
        int cycles;
        bit got;
        cycles = 0;
        while (busy && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        cmd_word  = cmd_tab[i];
        cmd_valid = 1'b1;
        @(negedge clk);
        got = rsp_valid;
        // busy is high now, so a second strobe with other data must be dropped
        cmd_valid = drop_tab[i];
        cmd_word  = {cmd_tab[i][31:16], ~cmd_tab[i][15:0]};
        cycles = 0;
        while (!got && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            got = rsp_valid;
            cycles++;
        end
        cmd_valid = 1'b0;
        if (!got) begin
            errors++;
            $display("no response to entry %0d within %0d cycles", i, RSP_TIMEOUT);
        end else begin
            check_value($sformatf("entry %0d rsp_err", i), 32'(rsp_err), 32'(err_tab[i]));
            check_value($sformatf("entry %0d rsp_data", i), 32'(rsp_data), 32'(data_tab[i]));
            check_value($sformatf("entry %0d bank_paused", i), 32'(bank_paused),
                        32'(paused_tab[i]));
        end
        repeat (drop_tab[i] ? 3 : 1) begin
            @(negedge clk);
            check_value($sformatf("entry %0d rsp_valid after", i), 32'(rsp_valid), 32'd0);
            check_value($sformatf("entry %0d busy after", i), 32'(busy), 32'd0);
        end
    endtask

    task automatic report_test(input int test, input int errors_before);
        if (errors > errors_before) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", test + 1, test_name[test], errors - errors_before);
    endtask

    initial begin
        int start;
        cpu_resetn   = 1'b0;
        cmd_valid    = 1'b0;
        cmd_word     = '0;
        seed         = 32'hfc99;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        test_name = '{"reset", "write and read-back", "pause", "resume and reset",
                      "illegal commands", "random sequence"};
        build_table();
        repeat (4) @(negedge clk);
        cpu_resetn = 1'b1;
        // stretched reset, busy held and nothing answered
        repeat (soc_cfg_pkg::RST_STRETCH) begin
            @(negedge clk);
            check_value("busy in reset", 32'(busy), 32'd1);
            check_value("bank_paused in reset", 32'(bank_paused), 32'd0);
            check_value("rsp_valid in reset", 32'(rsp_valid), 32'd0);
        end
        @(negedge clk);
        check_value("busy after reset", 32'(busy), 32'd0);
        report_test(0, 0);
        start = errors;
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
            if (i == n_entries - 1 || test_tab[i + 1] != test_tab[i]) begin
                report_test(test_tab[i], start);
                start = errors;
            end
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors", 6, failed_tests, checks,
                 errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog/soc_board_top.sv ====
`timescale 1ns/10ps

module soc_board_top (
    input  logic clk,
    input  logic cpu_resetn,

    input  logic                               cmd_valid,
    input  logic [soc_cfg_pkg::CMD_WIDTH-1:0]  cmd_word,

    output logic                               rsp_valid,
    output logic [soc_cfg_pkg::DATA_WIDTH-1:0] rsp_data,
    output logic                               rsp_err,
    output logic                               busy,

    output logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_paused
);

    logic rst;
    logic tick;

    // shared access lines, per-bank select and control
    logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_req;
    logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_we;
    logic [soc_cfg_pkg::ADDR_WIDTH-1:0] bank_addr;
    logic [soc_cfg_pkg::DATA_WIDTH-1:0] bank_wdata;
    logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_rst;
    logic [soc_cfg_pkg::NO_BANKS-1:0]   pause_req;

    logic [soc_cfg_pkg::DATA_WIDTH-1:0] bank_rdata [soc_cfg_pkg::NO_BANKS];
    logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_done;

    domain_seq u_seq (
        .clk        (clk),
        .cpu_resetn (cpu_resetn),
        .rst        (rst),
        .tick       (tick)
    );

    domain_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .rsp_err     (rsp_err),
        .busy        (busy),
        .bank_req    (bank_req),
        .bank_we     (bank_we),
        .bank_addr   (bank_addr),
        .bank_wdata  (bank_wdata),
        .bank_rst    (bank_rst),
        .pause_req   (pause_req),
        .bank_rdata  (bank_rdata),
        .bank_done   (bank_done),
        .bank_paused (bank_paused)
    );

    // memory banks, each with its own reset and pause
    for (genvar i = 0; i < soc_cfg_pkg::NO_BANKS; i++) begin : g_bank
        bank_ram u_bank (
            .clk       (clk),
            .rst       (rst),
            .bank_rst  (bank_rst[i]),
            .tick      (tick),
            .req       (bank_req[i]),
            .we        (bank_we[i]),
            .addr      (bank_addr),
            .wdata     (bank_wdata),
            .pause_req (pause_req[i]),
            .rdata     (bank_rdata[i]),
            .done      (bank_done[i]),
            .paused    (bank_paused[i])
        );
    end

endmodule

// ==== verilog/domain_ctrl.sv ====
`timescale 1ns/10ps

module domain_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic                   cmd_valid,
    input  soc_cmd_pkg::cmd_word_u cmd_word,

    output logic                               rsp_valid,
    output logic [soc_cfg_pkg::DATA_WIDTH-1:0] rsp_data,
    output logic                               rsp_err,
    output logic                               busy,

    output logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_req,
    output logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_we,
    output logic [soc_cfg_pkg::ADDR_WIDTH-1:0] bank_addr,
    output logic [soc_cfg_pkg::DATA_WIDTH-1:0] bank_wdata,

    output logic [soc_cfg_pkg::NO_BANKS-1:0] bank_rst,
    output logic [soc_cfg_pkg::NO_BANKS-1:0] pause_req,

    input  logic [soc_cfg_pkg::DATA_WIDTH-1:0] bank_rdata [soc_cfg_pkg::NO_BANKS],
    input  logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_done,
    input  logic [soc_cfg_pkg::NO_BANKS-1:0]   bank_paused
);

    logic [soc_cmd_pkg::STATE_WIDTH-1:0] state;
    logic                                pend;
    soc_cmd_pkg::cmd_word_u              cmd_q;
    logic [soc_cfg_pkg::NO_BANKS-1:0]    pause_q;
    logic [soc_cfg_pkg::DATA_WIDTH-1:0]  data_q;
    logic                                err_q;

    soc_cmd_pkg::cmd_op_t                   op;
    logic [soc_cmd_pkg::BANK_SEL_WIDTH-1:0] sel;
    logic [soc_cfg_pkg::NO_BANKS-1:0]       mask;
    logic [soc_cfg_pkg::NO_BANKS-1:0]       sel_hot;
    logic                                   accept;
    logic                                   decode;
    logic                                   is_access;
    logic                                   access_ok;
    logic                                   acc_done;
    logic                                   req_on;

    // both views share the opcode field
    assign op   = cmd_q.mem.op;
    assign sel  = cmd_q.mem.bank;
    assign mask = cmd_q.ctrl.mask;

    // one-hot bank select, all zero for an out-of-range bank number
    always_comb begin
        for (int i = 0; i < soc_cfg_pkg::NO_BANKS; i++) begin
            sel_hot[i] = (int'(sel) == i);
        end
    end

    assign accept    = cmd_valid && !busy;
    assign decode    = (state == soc_cmd_pkg::IDLE) && pend;
    assign is_access = (op == soc_cmd_pkg::OP_READ) || (op == soc_cmd_pkg::OP_WRITE);
    assign access_ok = (|sel_hot) && !(|(bank_paused & sel_hot));
    assign acc_done  = |(bank_done & sel_hot);

    // req goes out already in the decode cycle and holds until done
    assign req_on = (decode && is_access && access_ok) || (state == soc_cmd_pkg::ACCESS);

    assign bank_req   = req_on ? sel_hot : '0;
    assign bank_we    = (op == soc_cmd_pkg::OP_WRITE) ? bank_req : '0;
    assign bank_addr  = cmd_q.mem.addr;
    assign bank_wdata = cmd_q.mem.wdata;

    // single-cycle reset pulse to the masked banks
    assign bank_rst  = (decode && op == soc_cmd_pkg::OP_RESET) ? mask : '0;
    assign pause_req = pause_q;

    assign rsp_valid = (state == soc_cmd_pkg::RESPOND);
    assign rsp_data  = data_q;
    assign rsp_err   = err_q;

    // command and read data registers
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_word;
        end
        if (decode) begin
            data_q <= '0;
        end else if (state == soc_cmd_pkg::ACCESS && acc_done &&
                     op == soc_cmd_pkg::OP_READ) begin
            data_q <= bank_rdata[sel];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= soc_cmd_pkg::IDLE;
            pend    <= 1'b0;
            busy    <= 1'b1;
            pause_q <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state)
                soc_cmd_pkg::IDLE: begin
                    if (pend) begin
                        pend  <= 1'b0;
                        err_q <= 1'b0;
                        state <= soc_cmd_pkg::RESPOND;
                        case (op)
                            soc_cmd_pkg::OP_READ, soc_cmd_pkg::OP_WRITE: begin
                                if (access_ok) begin
                                    state <= soc_cmd_pkg::ACCESS;
                                end else begin
                                    err_q <= 1'b1;
                                end
                            end
                            soc_cmd_pkg::OP_PAUSE: begin
                                pause_q <= pause_q | mask;
                                state   <= soc_cmd_pkg::PAUSE_WAIT;
                            end
                            soc_cmd_pkg::OP_RESUME: begin
                                pause_q <= pause_q & ~mask;
                                state   <= soc_cmd_pkg::RESUME_WAIT;
                            end
                            soc_cmd_pkg::OP_RESET: begin
                                pause_q <= pause_q & ~mask;
                            end
                            default: begin
                                err_q <= 1'b1;
                            end
                        endcase
                    end else begin
                        // first cycle after rst still shows busy high
                        busy <= accept;
                        pend <= accept;
                    end
                end
                soc_cmd_pkg::ACCESS: begin
                    if (acc_done) begin
                        state <= soc_cmd_pkg::RESPOND;
                    end
                end
                soc_cmd_pkg::PAUSE_WAIT: begin
                    if ((bank_paused & mask) == mask) begin
                        state <= soc_cmd_pkg::RESPOND;
                    end
                end
                soc_cmd_pkg::RESUME_WAIT: begin
                    if ((bank_paused & mask) == '0) begin
                        state <= soc_cmd_pkg::RESPOND;
                    end
                end
                soc_cmd_pkg::RESPOND: begin
                    busy  <= 1'b0;
                    state <= soc_cmd_pkg::IDLE;
                end
                default: begin
                    state <= soc_cmd_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/bank_ram.sv ====
`timescale 1ns/10ps

module bank_ram (
    input  logic clk,
    input  logic rst,
    input  logic bank_rst,
    input  logic tick,

    input  logic                               req,
    input  logic                               we,
    input  logic [soc_cfg_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [soc_cfg_pkg::DATA_WIDTH-1:0] wdata,

    input  logic pause_req,

    output logic [soc_cfg_pkg::DATA_WIDTH-1:0] rdata,
    output logic                               done,
    output logic                               paused
);

    logic [soc_cfg_pkg::DATA_WIDTH-1:0] mem [soc_cfg_pkg::BANK_DEPTH];

    logic local_rst;
    logic access;

    assign local_rst = rst || bank_rst;

    // req is a level, so done from the last access blocks a second one
    assign access = req && tick && !done && !local_rst;

    // array and read register, contents survive either reset
    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // done follows the access by one cycle, together with rdata
    always_ff @(posedge clk) begin
        if (local_rst) begin
            done <= 1'b0;
        end else begin
            done <= access;
        end
    end

    // two-state pause machine, moves only on the tick
    // pause is granted when no access is waiting
    always_ff @(posedge clk) begin
        if (local_rst) begin
            paused <= 1'b0;
        end else if (tick) begin
            if (!paused && pause_req && !req) begin
                paused <= 1'b1;
            end else if (paused && !pause_req) begin
                paused <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/domain_seq.sv ====
`timescale 1ns/10ps

module domain_seq (
    input  logic clk,
    input  logic cpu_resetn,

    output logic rst,
    output logic tick
);

    logic [soc_cfg_pkg::RST_CNT_WIDTH-1:0] rst_cnt;
    logic [soc_cfg_pkg::DIV_WIDTH-1:0]     div_cnt;

    // stretch the board reset so the banks see a clean release
    always_ff @(posedge clk) begin
        if (!cpu_resetn) begin
            rst_cnt <= '0;
            rst     <= 1'b1;
        end else if (int'(rst_cnt) == soc_cfg_pkg::RST_STRETCH - 1) begin
            rst <= 1'b0;
        end else begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // clock enable for the bank domain
    // tick fires when the divider wraps, so it stays low all through rst
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= &div_cnt;
        end
    end

endmodule

// ==== verilog/soc_cmd_pkg.sv ====
package soc_cmd_pkg;

    localparam int OP_WIDTH       = 4;
    localparam int BANK_SEL_WIDTH = 2;

    // control view pads out whatever the opcode and mask leave over
    localparam int PAD_WIDTH = soc_cfg_pkg::CMD_WIDTH - OP_WIDTH - soc_cfg_pkg::NO_BANKS;

    // opcodes, anything else is rejected by the controller
    typedef enum logic [OP_WIDTH-1:0] {
        OP_READ   = 4'h1,
        OP_WRITE  = 4'h2,
        OP_PAUSE  = 4'h3,
        OP_RESUME = 4'h4,
        OP_RESET  = 4'h5
    } cmd_op_t;

    // memory access view
    typedef struct packed {
        cmd_op_t                              op;
        logic [BANK_SEL_WIDTH-1:0]            bank;
        logic [soc_cfg_pkg::ADDR_WIDTH-1:0]   addr;
        logic [soc_cfg_pkg::DATA_WIDTH-1:0]   wdata;
    } cmd_mem_t;

    // bank control view, one mask bit per bank
    typedef struct packed {
        cmd_op_t                            op;
        logic [soc_cfg_pkg::NO_BANKS-1:0]   mask;
        logic [PAD_WIDTH-1:0]               pad;
    } cmd_ctrl_t;

    typedef union packed {
        cmd_mem_t  mem;
        cmd_ctrl_t ctrl;
    } cmd_word_u;

    // controller states
    localparam int STATE_WIDTH = 3;

    localparam logic [STATE_WIDTH-1:0] IDLE        = 3'd0;
    localparam logic [STATE_WIDTH-1:0] ACCESS      = 3'd1;
    localparam logic [STATE_WIDTH-1:0] PAUSE_WAIT  = 3'd2;
    localparam logic [STATE_WIDTH-1:0] RESUME_WAIT = 3'd3;
    localparam logic [STATE_WIDTH-1:0] RESPOND     = 3'd4;

endpackage

// ==== verilog/soc_cfg_pkg.sv ====
package soc_cfg_pkg;

    // bank layout
    localparam int NO_BANKS   = 3;
    localparam int BANK_DEPTH = 1024;

    // word address inside one bank
    localparam int ADDR_WIDTH = 10;

    // data word carried to and from the banks
    localparam int DATA_WIDTH = 16;

    // full command word on the top-level port
    localparam int CMD_WIDTH = 32;

    // cycles of internal reset after the board reset releases
    localparam int RST_STRETCH   = 16;
    localparam int RST_CNT_WIDTH = $clog2(RST_STRETCH);

    // divider for the bank clock enable, 1 bit gives a tick every 2nd cycle
    localparam int DIV_WIDTH = 1;

endpackage
